//--- common/pmp_pkg.sv
package pmp_pkg;

    // Sizes
    localparam int PMP_ADDR_W   = 32;
    localparam int PMP_REGIONS  = 8;
    localparam int PMP_REGION_W = 3;
    localparam int PMP_ID_W     = 4;
    localparam int PMP_QDEPTH   = 4;   // Also the initial credit count of a requester

    // Bit positions of the flags inside a configuration data word
    localparam int PMP_FL_X = 0;
    localparam int PMP_FL_W = 1;
    localparam int PMP_FL_R = 2;
    localparam int PMP_FL_L = 3;
    localparam int PMP_FL_V = 4;

    typedef struct packed {
        logic v;   // Region valid
        logic l;   // Locked, also applies in machine mode
        logic r;
        logic w;
        logic x;
    } pmp_flags_t;

    typedef struct packed {
        logic [PMP_ADDR_W-1:0] start_addr;
        logic [PMP_ADDR_W-1:0] end_addr;   // Inclusive
        pmp_flags_t            flags;
    } pmp_region_t;

    typedef enum logic [1:0] {
        SEL_START = 2'd0,
        SEL_END   = 2'd1,
        SEL_FLAGS = 2'd2
    } pmp_csr_sel_e;

    typedef struct packed {
        pmp_csr_sel_e            sel;
        logic [PMP_REGION_W-1:0] region;
        logic [PMP_ADDR_W-1:0]   data;   // Flags use the low bits only
    } pmp_csr_wr_t;

    typedef struct packed {
        logic [PMP_ID_W-1:0]   id;
        logic [PMP_ADDR_W-1:0] addr;
        logic                  m_mode;
    } pmp_fetch_req_t;

    typedef struct packed {
        logic [PMP_ID_W-1:0]   id;
        logic [PMP_ADDR_W-1:0] addr;
        logic                  we;
        logic                  m_mode;
    } pmp_data_req_t;

    typedef struct packed {
        logic [PMP_ID_W-1:0] id;
        logic                fault;
    } pmp_rsp_t;

    typedef struct packed {
        logic hit;
        logic r;
        logic w;
        logic x;
    } pmp_perm_t;

endpackage

//--- pmp/pmp_table.sv
`timescale 1ns/1ps

module pmp_table import pmp_pkg::*; (
    input  logic                    i_clk,
    input  logic                    i_nrst,
    input  logic                    i_we,          // Commit from the CSR stage
    input  logic [PMP_REGION_W-1:0] i_region,
    input  pmp_region_t             i_entry,
    input  logic [PMP_ADDR_W-1:0]   i_iaddr,
    input  logic [PMP_ADDR_W-1:0]   i_daddr,
    input  logic                    i_m_mode_i,
    input  logic                    i_m_mode_d,
    output pmp_perm_t               o_iperm,
    output pmp_perm_t               o_dperm,
    output logic [PMP_REGIONS-1:0]  o_locked
);

    pmp_region_t tbl [PMP_REGIONS];

    // Scan from the top index down so the lowest matching region is the last to assign
    function automatic pmp_perm_t lookup(
        input logic [PMP_ADDR_W-1:0] addr,
        input logic                  m_mode
    );
        pmp_perm_t perm;
        logic      in_range;
        logic      applies;

        perm = '0;
        for (int i = PMP_REGIONS - 1; i >= 0; i--) begin
            in_range = (addr >= tbl[i].start_addr) && (addr <= tbl[i].end_addr);
            applies  = tbl[i].flags.v && (!m_mode || tbl[i].flags.l);
            if (in_range && applies) begin
                perm.hit = 1'b1;
                perm.r   = tbl[i].flags.r;
                perm.w   = tbl[i].flags.w;
                perm.x   = tbl[i].flags.x;
            end
        end
        return perm;
    endfunction

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int i = 0; i < PMP_REGIONS; i++) begin
                tbl[i] <= '0;   // No valid regions after reset
            end
        end else if (i_we) begin
            tbl[i_region] <= i_entry;
        end
    end

    // Both ports are looked up in parallel
    always_comb begin
        o_iperm = lookup(i_iaddr, i_m_mode_i);
        o_dperm = lookup(i_daddr, i_m_mode_d);
    end

    always_comb begin
        for (int i = 0; i < PMP_REGIONS; i++) begin
            o_locked[i] = tbl[i].flags.l;
        end
    end

    // The CSR stage must filter every write that targets a locked region
    a_no_locked_write: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        i_we |-> !o_locked[i_region]
    );

endmodule

//--- src/pmp_csr.sv
`timescale 1ns/1ps

module pmp_csr import pmp_pkg::*; (
    input  logic                    i_clk,
    input  logic                    i_nrst,
    input  logic                    i_wr_valid,
    input  pmp_csr_wr_t             i_wr,
    input  logic [PMP_REGIONS-1:0]  i_locked,      // Lock state as held in the table
    output logic                    o_tbl_we,
    output logic [PMP_REGION_W-1:0] o_tbl_region,
    output pmp_region_t             o_tbl_entry
);

    logic [PMP_ADDR_W-1:0]  stage_start [PMP_REGIONS];
    logic [PMP_ADDR_W-1:0]  stage_end   [PMP_REGIONS];
    logic [PMP_REGIONS-1:0] locked_eff;
    logic                   wr_ok;
    pmp_flags_t             new_flags;
    pmp_region_t            new_entry;

    always_comb begin
        // A commit still on its way to the table counts as locked already
        locked_eff = i_locked;
        if (o_tbl_we && o_tbl_entry.flags.l) begin
            locked_eff[o_tbl_region] = 1'b1;
        end
        wr_ok = i_wr_valid && !locked_eff[i_wr.region];

        new_flags.v = i_wr.data[PMP_FL_V];
        new_flags.l = i_wr.data[PMP_FL_L];
        new_flags.r = i_wr.data[PMP_FL_R];
        new_flags.w = i_wr.data[PMP_FL_W];
        new_flags.x = i_wr.data[PMP_FL_X];

        new_entry.flags = new_flags;
        if (new_flags.v) begin
            new_entry.start_addr = stage_start[i_wr.region];
            new_entry.end_addr   = stage_end[i_wr.region];
        end else begin
            new_entry.start_addr = '0;   // Invalid region keeps no range
            new_entry.end_addr   = '0;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int i = 0; i < PMP_REGIONS; i++) begin
                stage_start[i] <= '0;
                stage_end[i]   <= '0;
            end
            o_tbl_we     <= 1'b0;
            o_tbl_region <= '0;
            o_tbl_entry  <= '0;
        end else begin
            o_tbl_we <= 1'b0;
            if (wr_ok) begin
                case (i_wr.sel)
                    SEL_START: stage_start[i_wr.region] <= i_wr.data;
                    SEL_END:   stage_end[i_wr.region]   <= i_wr.data;
                    SEL_FLAGS: begin
                        o_tbl_we     <= 1'b1;   // Flags write commits the whole entry
                        o_tbl_region <= i_wr.region;
                        o_tbl_entry  <= new_entry;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- src/pmp_req_queue.sv
`timescale 1ns/1ps

module pmp_req_queue import pmp_pkg::*; #(
    parameter type payload_t = logic
) (
    input  logic     i_clk,
    input  logic     i_nrst,
    input  logic     i_push,
    input  payload_t i_data,
    input  logic     i_pop,
    output payload_t o_data,
    output logic     o_empty,
    output logic     o_credit      // One pulse per popped entry
);

    payload_t                          mem [PMP_QDEPTH];
    logic [$clog2(PMP_QDEPTH)-1:0]     wr_ptr;
    logic [$clog2(PMP_QDEPTH)-1:0]     rd_ptr;
    logic [$clog2(PMP_QDEPTH + 1)-1:0] count;
    logic                              head_fresh;   // Head was written at the last edge
    logic                              full;

    assign full    = (count == PMP_QDEPTH);
    assign o_data  = mem[rd_ptr];
    // A freshly written head waits one cycle before it is offered
    assign o_empty = (count == 0) || head_fresh;

    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            head_fresh <= 1'b0;
            o_credit   <= 1'b0;
        end else begin
            if (i_push) begin
                wr_ptr <= (wr_ptr == PMP_QDEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= (rd_ptr == PMP_QDEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({i_push, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            head_fresh <= i_push && (count == (i_pop ? 1 : 0));
            o_credit   <= i_pop;
        end
    end

    a_no_push_full: assert property (
        @(posedge i_clk) disable iff (!i_nrst) !(i_push && full)
    );

    a_no_pop_empty: assert property (
        @(posedge i_clk) disable iff (!i_nrst) !(i_pop && o_empty)
    );

endmodule

//--- src/pmp_checker.sv
`timescale 1ns/1ps

module pmp_checker import pmp_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_nrst,
    input  pmp_fetch_req_t        i_ihead,
    input  logic                  i_iempty,
    input  pmp_data_req_t         i_dhead,
    input  logic                  i_dempty,
    input  pmp_perm_t             i_iperm,       // Lookup result for the fetch head
    input  pmp_perm_t             i_dperm,       // Lookup result for the data head
    output logic                  o_ipop,
    output logic                  o_dpop,
    output logic [PMP_ADDR_W-1:0] o_iaddr,
    output logic [PMP_ADDR_W-1:0] o_daddr,
    output logic                  o_m_mode_i,
    output logic                  o_m_mode_d,
    output logic                  o_irsp_valid,
    output pmp_rsp_t              o_irsp,
    output logic                  o_drsp_valid,
    output pmp_rsp_t              o_drsp
);

    pmp_rsp_t irsp_next;
    pmp_rsp_t drsp_next;
    logic     dallow;

    // Queues drain independently, one entry per cycle each
    assign o_ipop = !i_iempty;
    assign o_dpop = !i_dempty;

    assign o_iaddr    = i_ihead.addr;
    assign o_daddr    = i_dhead.addr;
    assign o_m_mode_i = i_ihead.m_mode;
    assign o_m_mode_d = i_dhead.m_mode;

    always_comb begin
        irsp_next.id = i_ihead.id;
        // No hit means fault in user mode and allow in machine mode
        if (i_iperm.hit) begin
            irsp_next.fault = !i_iperm.x;
        end else begin
            irsp_next.fault = !i_ihead.m_mode;
        end
    end

    always_comb begin
        dallow       = i_dhead.we ? i_dperm.w : i_dperm.r;   // Store needs w, load needs r
        drsp_next.id = i_dhead.id;
        if (i_dperm.hit) begin
            drsp_next.fault = !dallow;
        end else begin
            drsp_next.fault = !i_dhead.m_mode;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_irsp_valid <= 1'b0;
            o_drsp_valid <= 1'b0;
        end else begin
            o_irsp_valid <= o_ipop;
            o_drsp_valid <= o_dpop;
        end
    end

    // Response payload is captured on each pop
    always_ff @(posedge i_clk) begin
        if (o_ipop) begin
            o_irsp <= irsp_next;
        end
        if (o_dpop) begin
            o_drsp <= drsp_next;
        end
    end

endmodule

//--- src/pmp_top.sv
`timescale 1ns/1ps

module pmp_top import pmp_pkg::*; (
    input  logic           i_clk,
    input  logic           i_nrst,
    input  logic           i_cfg_valid,
    input  pmp_csr_wr_t    i_cfg,
    input  logic           i_ireq_valid,
    input  pmp_fetch_req_t i_ireq,
    output logic           o_icredit,
    input  logic           i_dreq_valid,
    input  pmp_data_req_t  i_dreq,
    output logic           o_dcredit,
    output logic           o_irsp_valid,
    output pmp_rsp_t       o_irsp,
    output logic           o_drsp_valid,
    output pmp_rsp_t       o_drsp
);

    logic                    tbl_we;
    logic [PMP_REGION_W-1:0] tbl_region;
    pmp_region_t             tbl_entry;
    logic [PMP_REGIONS-1:0]  locked;
    pmp_fetch_req_t          ihead;
    pmp_data_req_t           dhead;
    logic                    iempty;
    logic                    dempty;
    logic                    ipop;
    logic                    dpop;
    logic [PMP_ADDR_W-1:0]   iaddr;
    logic [PMP_ADDR_W-1:0]   daddr;
    logic                    m_mode_i;
    logic                    m_mode_d;
    pmp_perm_t               iperm;
    pmp_perm_t               dperm;

    pmp_csr u_csr (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_wr_valid   (i_cfg_valid),
        .i_wr         (i_cfg),
        .i_locked     (locked),
        .o_tbl_we     (tbl_we),
        .o_tbl_region (tbl_region),
        .o_tbl_entry  (tbl_entry)
    );

    pmp_table u_table (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_we       (tbl_we),
        .i_region   (tbl_region),
        .i_entry    (tbl_entry),
        .i_iaddr    (iaddr),
        .i_daddr    (daddr),
        .i_m_mode_i (m_mode_i),
        .i_m_mode_d (m_mode_d),
        .o_iperm    (iperm),
        .o_dperm    (dperm),
        .o_locked   (locked)
    );

    pmp_req_queue #(.payload_t(pmp_fetch_req_t)) u_iq (
        .i_clk    (i_clk),
        .i_nrst   (i_nrst),
        .i_push   (i_ireq_valid),
        .i_data   (i_ireq),
        .i_pop    (ipop),
        .o_data   (ihead),
        .o_empty  (iempty),
        .o_credit (o_icredit)
    );

    pmp_req_queue #(.payload_t(pmp_data_req_t)) u_dq (
        .i_clk    (i_clk),
        .i_nrst   (i_nrst),
        .i_push   (i_dreq_valid),
        .i_data   (i_dreq),
        .i_pop    (dpop),
        .o_data   (dhead),
        .o_empty  (dempty),
        .o_credit (o_dcredit)
    );

    pmp_checker u_checker (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_ihead      (ihead),
        .i_iempty     (iempty),
        .i_dhead      (dhead),
        .i_dempty     (dempty),
        .i_iperm      (iperm),
        .i_dperm      (dperm),
        .o_ipop       (ipop),
        .o_dpop       (dpop),
        .o_iaddr      (iaddr),
        .o_daddr      (daddr),
        .o_m_mode_i   (m_mode_i),
        .o_m_mode_d   (m_mode_d),
        .o_irsp_valid (o_irsp_valid),
        .o_irsp       (o_irsp),
        .o_drsp_valid (o_drsp_valid),
        .o_drsp       (o_drsp)
    );

endmodule

//--- verif/pmp_tb.sv
`timescale 1ns/1ps

module pmp_tb import pmp_pkg::*; ();

    localparam int NUM_PHASES     = 6;     // Phase 0 runs on the empty table
    localparam int REQS           = 40;    // Requests per port and phase
    localparam int TOTAL_REQS     = 2 * NUM_PHASES * REQS;
    localparam int CFG_CYCLES     = (NUM_PHASES - 1) * (3 * PMP_REGIONS + 4);
    localparam int RESET_CYCLES   = 4;
    localparam int TIMEOUT_CYCLES = 8 * TOTAL_REQS + CFG_CYCLES + RESET_CYCLES;

    logic           clk;
    logic           nrst;
    logic           cfg_valid;
    pmp_csr_wr_t    cfg;
    logic           ireq_valid;
    pmp_fetch_req_t ireq;
    logic           icredit;
    logic           dreq_valid;
    pmp_data_req_t  dreq;
    logic           dcredit;
    logic           irsp_valid;
    pmp_rsp_t       irsp;
    logic           drsp_valid;
    pmp_rsp_t       drsp;

    // Reference model of the region table
    logic [PMP_ADDR_W-1:0] st_start [PMP_REGIONS];
    logic [PMP_ADDR_W-1:0] st_end   [PMP_REGIONS];
    logic [PMP_ADDR_W-1:0] m_start  [PMP_REGIONS];
    logic [PMP_ADDR_W-1:0] m_end    [PMP_REGIONS];
    pmp_flags_t            m_flags  [PMP_REGIONS];

    pmp_rsp_t            iexp [$];   // Expected fetch responses in order
    pmp_rsp_t            dexp [$];
    integer              seed;
    int                  icredits;
    int                  dcredits;
    int                  cycles;
    int                  dropped_writes;
    int                  invalid_commits;
    logic [PMP_ID_W-1:0] iid;
    logic [PMP_ID_W-1:0] did;

    pmp_top dut0 (
        .i_clk        (clk),
        .i_nrst       (nrst),
        .i_cfg_valid  (cfg_valid),
        .i_cfg        (cfg),
        .i_ireq_valid (ireq_valid),
        .i_ireq       (ireq),
        .o_icredit    (icredit),
        .i_dreq_valid (dreq_valid),
        .i_dreq       (dreq),
        .o_dcredit    (dcredit),
        .o_irsp_valid (irsp_valid),
        .o_irsp       (irsp),
        .o_drsp_valid (drsp_valid),
        .o_drsp       (drsp)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Regression failed");
        $fatal(1);
    endtask

    // Lowest matching region decides, machine mode sees locked regions only
    function automatic logic expect_fault(
        input logic [PMP_ADDR_W-1:0] addr,
        input logic                  m_mode,
        input int                    kind        // 0 fetch, 1 load, 2 store
    );
        for (int i = 0; i < PMP_REGIONS; i++) begin
            if (m_flags[i].v && (!m_mode || m_flags[i].l) &&
                addr >= m_start[i] && addr <= m_end[i]) begin
                if (kind == 0) begin
                    return !m_flags[i].x;
                end else if (kind == 1) begin
                    return !m_flags[i].r;
                end
                return !m_flags[i].w;
            end
        end
        return !m_mode;   // Unmatched: user faults, machine passes
    endfunction

    task automatic cfg_write(input pmp_csr_sel_e sel, input int region,
                             input logic [PMP_ADDR_W-1:0] data);
        pmp_csr_wr_t w;
        pmp_flags_t  fl;

        w.sel    = sel;
        w.region = region[PMP_REGION_W-1:0];
        w.data   = data;
        fl       = data[4:0];
        @(posedge clk);
        cfg_valid <= 1'b1;
        cfg       <= w;
        if (m_flags[region].l) begin
            dropped_writes++;   // Locked until reset
        end else if (sel == SEL_START) begin
            st_start[region] = data;
        end else if (sel == SEL_END) begin
            st_end[region] = data;
        end else begin
            m_flags[region] = fl;
            m_start[region] = fl.v ? st_start[region] : '0;
            m_end[region]   = fl.v ? st_end[region] : '0;
            if (!fl.v) begin
                invalid_commits++;
            end
        end
    endtask

    task automatic config_phase();
        logic [31:0]           rnd;
        logic [PMP_ADDR_W-1:0] s;
        pmp_flags_t            fl;

        for (int i = 0; i < PMP_REGIONS; i++) begin
            rnd  = $random(seed);
            s    = {22'b0, rnd[9:0]};   // Small ranges so regions overlap
            fl.v = (rnd[26:25] != 2'b00);
            fl.l = (rnd[29:27] == 3'b000);
            fl.r = rnd[21];
            fl.w = rnd[22];
            fl.x = rnd[23];
            cfg_write(SEL_START, i, s);
            cfg_write(SEL_END, i, s + {24'b0, rnd[17:10]});
            cfg_write(SEL_FLAGS, i, {27'b0, fl});
        end
        @(posedge clk);
        cfg_valid <= 1'b0;
        repeat (3) @(posedge clk);   // Let the last commit reach the table
    endtask

    task automatic run_traffic(input bit burst);
        logic [31:0]    rnd;
        pmp_fetch_req_t fr;
        pmp_data_req_t  dr;
        pmp_rsp_t       e;
        int             isent;
        int             dsent;

        isent = 0;
        dsent = 0;
        while (isent < REQS || dsent < REQS) begin
            @(posedge clk);
            ireq_valid <= 1'b0;
            dreq_valid <= 1'b0;
            rnd = $random(seed);
            if (isent < REQS && icredits > 0 && (burst || rnd[1:0] != 2'b00)) begin
                fr.id     = iid;
                fr.addr   = (rnd[31:29] == 3'b000) ? $random(seed) : {22'b0, rnd[13:4]};
                fr.m_mode = rnd[2];
                e.id      = iid;
                e.fault   = expect_fault(fr.addr, fr.m_mode, 0);
                iexp.push_back(e);
                icredits--;
                iid++;
                isent++;
                ireq_valid <= 1'b1;
                ireq       <= fr;
            end
            rnd = $random(seed);
            if (dsent < REQS && dcredits > 0 && (burst || rnd[1:0] != 2'b00)) begin
                dr.id     = did;
                dr.addr   = (rnd[31:29] == 3'b000) ? $random(seed) : {22'b0, rnd[13:4]};
                dr.we     = rnd[3];
                dr.m_mode = rnd[2];
                e.id      = did;
                e.fault   = expect_fault(dr.addr, dr.m_mode, dr.we ? 2 : 1);
                dexp.push_back(e);
                dcredits--;
                did++;
                dsent++;
                dreq_valid <= 1'b1;
                dreq       <= dr;
            end
        end
        @(posedge clk);
        ireq_valid <= 1'b0;
        dreq_valid <= 1'b0;
        // Wait until every expected response has come back
        while (iexp.size() != 0 || dexp.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        assert (icredits == PMP_QDEPTH && dcredits == PMP_QDEPTH) else
            abort_run($sformatf("ERROR at %0t: idle credits fetch %0d data %0d, expected %0d",
                                $time, icredits, dcredits, PMP_QDEPTH));
    endtask

    // Outputs are sampled at the falling edge, away from the register updates
    always @(negedge clk) begin
        if (nrst) begin
            if (icredit) icredits++;
            if (dcredit) dcredits++;
            assert (icredits <= PMP_QDEPTH && dcredits <= PMP_QDEPTH) else
                abort_run("More credits were returned than requests were sent");
            if (irsp_valid) begin
                assert (iexp.size() > 0) else
                    abort_run("Fetch response arrived with no request outstanding");
                assert (irsp == iexp[0]) else
                    abort_run($sformatf("ERROR at %0t: fetch id %0h fault %0b, expected %0h %0b",
                                        $time, irsp.id, irsp.fault, iexp[0].id, iexp[0].fault));
                void'(iexp.pop_front());
            end
            if (drsp_valid) begin
                assert (dexp.size() > 0) else
                    abort_run("Data response arrived with no request outstanding");
                assert (drsp == dexp[0]) else
                    abort_run($sformatf("ERROR at %0t: data id %0h fault %0b, expected %0h %0b",
                                        $time, drsp.id, drsp.fault, dexp[0].id, dexp[0].fault));
                void'(dexp.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial begin
        seed            = 32'h814706f3;
        clk             = 1'b0;
        nrst            = 1'b0;
        cfg_valid       = 1'b0;
        cfg             = '0;
        ireq_valid      = 1'b0;
        ireq            = '0;
        dreq_valid      = 1'b0;
        dreq            = '0;
        icredits        = PMP_QDEPTH;
        dcredits        = PMP_QDEPTH;
        cycles          = 0;
        dropped_writes  = 0;
        invalid_commits = 0;
        iid             = '0;
        did             = '0;
        for (int i = 0; i < PMP_REGIONS; i++) begin
            st_start[i] = '0;
            st_end[i]   = '0;
            m_start[i]  = '0;
            m_end[i]    = '0;
            m_flags[i]  = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        nrst <= 1'b1;

        run_traffic(1'b0);   // Empty table
        for (int p = 1; p < NUM_PHASES; p++) begin
            config_phase();
            run_traffic(p[0]);   // Odd phases burst at full credit
        end

        assert (dropped_writes > 0) else
            abort_run("No configuration write ever targeted a locked region");
        assert (invalid_commits > 0) else
            abort_run("No region was ever committed with its valid flag clear");
        $display("Regression passed");
        $finish;
    end

endmodule

//--- list.f
common/pmp_pkg.sv
pmp/pmp_table.sv
src/pmp_csr.sv
src/pmp_req_queue.sv
src/pmp_checker.sv
src/pmp_top.sv
verif/pmp_tb.sv

//--- Bender.yml
package:
  name: pmp

sources:
  # Shared package first
  - common/pmp_pkg.sv
  # Design
  - pmp/pmp_table.sv
  - src/pmp_csr.sv
  - src/pmp_req_queue.sv
  - src/pmp_checker.sv
  - src/pmp_top.sv
  # Testbench
  - target: test
    files:
      - verif/pmp_tb.sv
